//--- design/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 16;
  localparam int MUL_CYCLES = XLEN;  // one multiplier bit per cycle

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_LI,
    OP_MUL
  } alu_op_t;

  typedef enum logic [1:0] {
    DS_IDLE,
    DS_ISSUE,
    DS_WAIT_DROP
  } dispatch_state_t;

endpackage

`default_nettype wire

//--- design/rename_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rename_regfile import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  reg_idx_t                     i_rs1,
  input  reg_idx_t                     i_rs2,
  input  wire                          i_rename_we,
  input  reg_idx_t                     i_rename_rd,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_rename_tag,
  input  wire                          i_commit_we,
  input  reg_idx_t                     i_commit_rd,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_commit_tag,
  input  word_t                        i_commit_value,
  output word_t                        o_src1_value,
  output logic                         o_src1_busy,
  output logic [$clog2(ROB_DEPTH)-1:0] o_src1_tag,
  output word_t                        o_src2_value,
  output logic                         o_src2_busy,
  output logic [$clog2(ROB_DEPTH)-1:0] o_src2_tag
);
  localparam int TW = $clog2(ROB_DEPTH);

  word_t         regs [NUM_REGS];
  logic          busy [NUM_REGS];
  logic [TW-1:0] tags [NUM_REGS];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;  // arch state starts at zero
        busy[i] <= 1'b0;
        tags[i] <= '0;
      end
    end else begin
      if (i_commit_we && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // only the newest producer frees the register
        if (tags[i_commit_rd] == i_commit_tag) busy[i_commit_rd] <= 1'b0;
      end
      if (i_rename_we && i_rename_rd != '0) begin  // overrides a same-cycle commit
        busy[i_rename_rd] <= 1'b1;
        tags[i_rename_rd] <= i_rename_tag;
      end
    end
  end

  assign o_src1_value = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_src1_busy  = busy[i_rs1];
  assign o_src1_tag   = tags[i_rs1];
  assign o_src2_value = (i_rs2 == '0) ? '0 : regs[i_rs2];
  assign o_src2_busy  = busy[i_rs2];
  assign o_src2_tag   = tags[i_rs2];

endmodule

`default_nettype wire

//--- design/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  wire                          i_alloc,
  input  reg_idx_t                     i_alloc_rd,
  input  wire                          i_cdb_valid,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_cdb_tag,
  input  word_t                        i_cdb_value,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_fwd1_tag,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_fwd2_tag,
  output logic [$clog2(ROB_DEPTH)-1:0] o_alloc_tag,
  output logic                         o_full,
  output word_t                        o_fwd1_value,
  output logic                         o_fwd1_done,
  output word_t                        o_fwd2_value,
  output logic                         o_fwd2_done,
  output logic                         o_commit_valid,
  output reg_idx_t                     o_commit_rd,
  output word_t                        o_commit_value,
  output logic [$clog2(ROB_DEPTH)-1:0] o_commit_tag
);
  localparam int TW = $clog2(ROB_DEPTH);

  reg_idx_t      rob_rd    [ROB_DEPTH];
  word_t         rob_value [ROB_DEPTH];
  logic          rob_done  [ROB_DEPTH];
  logic [TW-1:0] head, tail;
  logic [TW:0]   count;

  assign o_alloc_tag    = tail;
  assign o_full         = (count == (TW+1)'(ROB_DEPTH));
  assign o_commit_valid = (count != '0) && rob_done[head];
  assign o_commit_rd    = rob_rd[head];
  assign o_commit_value = rob_value[head];
  assign o_commit_tag   = head;

  // forward lookups also see this cycle's broadcast
  assign o_fwd1_done  = rob_done[i_fwd1_tag] || (i_cdb_valid && i_cdb_tag == i_fwd1_tag);
  assign o_fwd1_value = (i_cdb_valid && i_cdb_tag == i_fwd1_tag) ? i_cdb_value
                                                                  : rob_value[i_fwd1_tag];
  assign o_fwd2_done  = rob_done[i_fwd2_tag] || (i_cdb_valid && i_cdb_tag == i_fwd2_tag);
  assign o_fwd2_value = (i_cdb_valid && i_cdb_tag == i_fwd2_tag) ? i_cdb_value
                                                                  : rob_value[i_fwd2_tag];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) rob_done[i] <= 1'b0;
    end else begin
      if (i_alloc) begin
        rob_rd[tail]   <= i_alloc_rd;
        rob_done[tail] <= 1'b0;
        tail           <= tail + 1'b1;
      end
      if (i_cdb_valid) begin
        rob_done[i_cdb_tag]  <= 1'b1;
        rob_value[i_cdb_tag] <= i_cdb_value;
      end
      if (o_commit_valid) head <= head + 1'b1;
      count <= count + (TW+1)'(i_alloc) - (TW+1)'(o_commit_valid);
    end
  end

  a_no_alloc_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_alloc |-> !o_full);
  // a fresh entry starts out not done
  a_alloc_not_done: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_alloc |=> !rob_done[$past(tail)]);
  // retiring entry is no longer on the bus
  a_commit_done: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> !(i_cdb_valid && i_cdb_tag == head));

endmodule

`default_nettype wire

//--- design/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; #(
  parameter int ROB_DEPTH  = 8,
  parameter int RS_ENTRIES = 2
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  wire                          i_we,
  input  word_t                        i_a,
  input  word_t                        i_b,
  input  wire                          i_a_rdy,
  input  wire                          i_b_rdy,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_a_tag,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_b_tag,
  input  alu_op_t                      i_op,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_tag,
  input  wire                          i_unit_ready,
  input  wire                          i_cdb_valid,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_cdb_tag,
  input  word_t                        i_cdb_value,
  output logic                         o_full,
  output logic                         o_issue_valid,
  output word_t                        o_issue_a,
  output word_t                        o_issue_b,
  output alu_op_t                      o_issue_op,
  output logic [$clog2(ROB_DEPTH)-1:0] o_issue_tag
);
  localparam int TW = $clog2(ROB_DEPTH);
  localparam int IW = (RS_ENTRIES > 1) ? $clog2(RS_ENTRIES) : 1;

  logic          slot_valid [RS_ENTRIES];
  logic          slot_a_rdy [RS_ENTRIES];
  logic          slot_b_rdy [RS_ENTRIES];
  word_t         slot_a     [RS_ENTRIES];
  word_t         slot_b     [RS_ENTRIES];
  logic [TW-1:0] slot_a_tag [RS_ENTRIES];
  logic [TW-1:0] slot_b_tag [RS_ENTRIES];
  logic [TW-1:0] slot_tag   [RS_ENTRIES];
  alu_op_t       slot_op    [RS_ENTRIES];
  logic [IW-1:0] free_idx, issue_idx;
  logic          any_ready;

  always_comb begin
    o_full    = 1'b1;
    free_idx  = '0;
    any_ready = 1'b0;
    issue_idx = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin  // downward so lowest wins
      if (!slot_valid[i]) begin
        o_full   = 1'b0;
        free_idx = IW'(i);
      end
      if (slot_valid[i] && slot_a_rdy[i] && slot_b_rdy[i]) begin
        any_ready = 1'b1;
        issue_idx = IW'(i);
      end
    end
  end

  assign o_issue_valid = any_ready && i_unit_ready;
  assign o_issue_a     = slot_a[issue_idx];
  assign o_issue_b     = slot_b[issue_idx];
  assign o_issue_op    = slot_op[issue_idx];
  assign o_issue_tag   = slot_tag[issue_idx];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int i = 0; i < RS_ENTRIES; i++) slot_valid[i] <= 1'b0;
    end else begin
      for (int i = 0; i < RS_ENTRIES; i++) begin
        // bus snoop for operands still waiting
        if (i_cdb_valid && slot_valid[i] && !slot_a_rdy[i] && slot_a_tag[i] == i_cdb_tag) begin
          slot_a[i]     <= i_cdb_value;
          slot_a_rdy[i] <= 1'b1;
        end
        if (i_cdb_valid && slot_valid[i] && !slot_b_rdy[i] && slot_b_tag[i] == i_cdb_tag) begin
          slot_b[i]     <= i_cdb_value;
          slot_b_rdy[i] <= 1'b1;
        end
      end
      if (o_issue_valid) slot_valid[issue_idx] <= 1'b0;
      if (i_we && !o_full) begin
        slot_valid[free_idx] <= 1'b1;
        slot_a[free_idx]     <= i_a;
        slot_b[free_idx]     <= i_b;
        slot_a_rdy[free_idx] <= i_a_rdy;
        slot_b_rdy[free_idx] <= i_b_rdy;
        slot_a_tag[free_idx] <= i_a_tag;
        slot_b_tag[free_idx] <= i_b_tag;
        slot_op[free_idx]    <= i_op;
        slot_tag[free_idx]   <= i_tag;
      end
    end
  end

  // a write while every slot is taken would lose the instruction
  a_no_write_full: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    i_we |-> !o_full);

endmodule

`default_nettype wire

//--- design/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  wire                          i_valid,
  input  word_t                        i_a,
  input  word_t                        i_b,
  input  alu_op_t                      i_op,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_tag,
  input  wire                          i_grant,
  output logic                         o_ready,
  output logic                         o_result_valid,
  output word_t                        o_result,
  output logic [$clog2(ROB_DEPTH)-1:0] o_result_tag
);
  word_t alu_out;

  always_comb begin
    case (i_op)
      OP_ADD:  alu_out = i_a + i_b;  // wraps at XLEN
      OP_SUB:  alu_out = i_a - i_b;
      OP_AND:  alu_out = i_a & i_b;
      OP_OR:   alu_out = i_a | i_b;
      OP_XOR:  alu_out = i_a ^ i_b;
      OP_LI:   alu_out = i_b;
      default: alu_out = '0;
    endcase
  end

  assign o_ready = !o_result_valid || i_grant;  // free once the bus takes it

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      o_result_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      o_result_valid <= 1'b1;
    end else if (i_grant) begin
      o_result_valid <= 1'b0;
    end
    if (i_valid && o_ready) begin
      o_result     <= alu_out;
      o_result_tag <= i_tag;
    end
  end

endmodule

`default_nettype wire

//--- design/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  wire                          i_valid,
  input  word_t                        i_a,
  input  word_t                        i_b,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_tag,
  input  wire                          i_grant,
  output logic                         o_ready,
  output logic                         o_result_valid,
  output word_t                        o_result,
  output logic [$clog2(ROB_DEPTH)-1:0] o_result_tag
);
  localparam int CW = $clog2(MUL_CYCLES + 1);

  word_t         mcand, mplier, acc;
  logic [CW-1:0] cnt;
  logic          busy;

  assign o_ready  = !busy && (!o_result_valid || i_grant);
  assign o_result = acc;  // low XLEN bits of the product

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy           <= 1'b0;
      cnt            <= '0;
      o_result_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      busy           <= 1'b1;
      cnt            <= '0;
      o_result_valid <= 1'b0;
    end else if (busy) begin
      cnt <= cnt + 1'b1;
      if (cnt == CW'(MUL_CYCLES - 1)) begin  // last bit taken this cycle
        busy           <= 1'b0;
        o_result_valid <= 1'b1;
      end
    end else if (i_grant) begin
      o_result_valid <= 1'b0;
    end
    if (i_valid && o_ready) begin
      mcand        <= i_a;
      mplier       <= i_b;
      acc          <= '0;
      o_result_tag <= i_tag;
    end else if (busy) begin
      if (mplier[0]) acc <= acc + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  a_cnt_bound: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    busy |-> cnt < CW'(MUL_CYCLES));

endmodule

`default_nettype wire

//--- design/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  wire                          i_alu_valid,
  input  word_t                        i_alu_value,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_alu_tag,
  input  wire                          i_mul_valid,
  input  word_t                        i_mul_value,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_mul_tag,
  output logic                         o_alu_grant,
  output logic                         o_mul_grant,
  output logic                         o_cdb_valid,
  output logic [$clog2(ROB_DEPTH)-1:0] o_cdb_tag,
  output word_t                        o_cdb_value
);
  // alu always wins, mul waits a cycle
  assign o_alu_grant = i_alu_valid;
  assign o_mul_grant = i_mul_valid && !i_alu_valid;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) o_cdb_valid <= 1'b0;
    else o_cdb_valid <= o_alu_grant || o_mul_grant;
    o_cdb_tag   <= o_alu_grant ? i_alu_tag : i_mul_tag;
    o_cdb_value <= o_alu_grant ? i_alu_value : i_mul_value;
  end

endmodule

`default_nettype wire

//--- design/dispatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_ctrl import ooo_pkg::*; #(
  parameter int ROB_DEPTH = 8
) (
  input  wire                          clk_100mhz,
  input  wire                          sys_rst,
  input  wire                          i_inst_req,
  input  alu_op_t                      i_inst_op,
  input  reg_idx_t                     i_inst_rd,
  input  word_t                        i_inst_imm,
  input  word_t                        i_src1_value,
  input  wire                          i_src1_busy,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_src1_tag,
  input  word_t                        i_src2_value,
  input  wire                          i_src2_busy,
  input  wire [$clog2(ROB_DEPTH)-1:0]  i_src2_tag,
  input  word_t                        i_fwd1_value,
  input  wire                          i_fwd1_done,
  input  word_t                        i_fwd2_value,
  input  wire                          i_fwd2_done,
  input  wire                          i_rob_full,
  input  wire                          i_alu_rs_full,
  input  wire                          i_mul_rs_full,
  output logic                         o_inst_ack,
  output logic                         o_rob_alloc,
  output logic                         o_rename_we,
  output logic                         o_alu_rs_we,
  output logic                         o_mul_rs_we,
  output word_t                        o_entry_a,
  output word_t                        o_entry_b,
  output logic                         o_entry_a_rdy,
  output logic                         o_entry_b_rdy,
  output logic [$clog2(ROB_DEPTH)-1:0] o_entry_a_tag,
  output logic [$clog2(ROB_DEPTH)-1:0] o_entry_b_tag,
  output alu_op_t                      o_entry_op
);
  dispatch_state_t state, state_nxt;
  logic is_mul, room, go;

  always_comb begin
    is_mul = (i_inst_op == OP_MUL);
    room   = !i_rob_full && (is_mul ? !i_mul_rs_full : !i_alu_rs_full);
    go     = (state == DS_ISSUE) && room;

    state_nxt = state;
    case (state)
      DS_IDLE:      if (i_inst_req) state_nxt = DS_ISSUE;
      DS_ISSUE:     if (room) state_nxt = DS_WAIT_DROP;  // stalls here on full
      DS_WAIT_DROP: if (!i_inst_req) state_nxt = DS_IDLE;
      default:      state_nxt = DS_IDLE;
    endcase
  end

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) state <= DS_IDLE;
    else state <= state_nxt;
  end

  assign o_inst_ack  = (state == DS_WAIT_DROP);
  assign o_rob_alloc = go;
  assign o_rename_we = go && (i_inst_rd != '0);  // r0 stays unrenamed
  assign o_alu_rs_we = go && !is_mul;
  assign o_mul_rs_we = go && is_mul;
  assign o_entry_op  = i_inst_op;
  assign o_entry_a_tag = i_src1_tag;
  assign o_entry_b_tag = i_src2_tag;

  // operand sources: load-imm, register, rob forward, else wait on tag
  always_comb begin
    o_entry_a     = i_src1_value;
    o_entry_a_rdy = !i_src1_busy || i_fwd1_done;
    if (i_src1_busy) o_entry_a = i_fwd1_value;
    o_entry_b     = i_src2_value;
    o_entry_b_rdy = !i_src2_busy || i_fwd2_done;
    if (i_src2_busy) o_entry_b = i_fwd2_value;
    if (i_inst_op == OP_LI) begin
      o_entry_a     = i_inst_imm;
      o_entry_b     = i_inst_imm;
      o_entry_a_rdy = 1'b1;
      o_entry_b_rdy = 1'b1;
    end
  end

  // source must still be requesting when ack goes up
  a_ack_needs_req: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    $rose(o_inst_ack) |-> i_inst_req);

endmodule

`default_nettype wire

//--- design/ooo_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_top import ooo_pkg::*; #(
  parameter int ROB_DEPTH  = 8,
  parameter int RS_ENTRIES = 2
) (
  input  wire      clk_100mhz,
  input  wire      sys_rst,
  input  wire      i_inst_req,
  input  alu_op_t  i_inst_op,
  input  reg_idx_t i_inst_rd,
  input  reg_idx_t i_inst_rs1,
  input  reg_idx_t i_inst_rs2,
  input  word_t    i_inst_imm,
  output logic     o_inst_ack,
  output logic     o_commit_valid,
  output reg_idx_t o_commit_rd,
  output word_t    o_commit_value
);
  localparam int TW = $clog2(ROB_DEPTH);

  // register read and forwarding
  word_t          src1_value, src2_value, fwd1_value, fwd2_value;
  logic           src1_busy, src2_busy, fwd1_done, fwd2_done;
  logic [TW-1:0]  src1_tag, src2_tag;

  // dispatch to rob, rename table and stations
  logic           rob_alloc, rob_full, rename_we;
  logic [TW-1:0]  alloc_tag, commit_tag;
  logic           alu_rs_we, mul_rs_we, alu_rs_full, mul_rs_full;
  word_t          entry_a, entry_b;
  logic           entry_a_rdy, entry_b_rdy;
  logic [TW-1:0]  entry_a_tag, entry_b_tag;
  alu_op_t        entry_op;

  // station to unit
  logic           alu_ready, alu_issue, mul_ready, mul_issue;
  word_t          alu_a, alu_b, mul_a, mul_b;
  alu_op_t        alu_op;
  logic [TW-1:0]  alu_in_tag, mul_in_tag;

  // unit results and bus
  logic           alu_res_valid, mul_res_valid, alu_grant, mul_grant;
  word_t          alu_result, mul_result, cdb_value;
  logic [TW-1:0]  alu_res_tag, mul_res_tag, cdb_tag;
  logic           cdb_valid;

  dispatch_ctrl #(.ROB_DEPTH(ROB_DEPTH)) u_dispatch (
    .clk_100mhz, .sys_rst, .i_inst_req, .i_inst_op, .i_inst_rd, .i_inst_imm,
    .i_src1_value(src1_value), .i_src1_busy(src1_busy), .i_src1_tag(src1_tag),
    .i_src2_value(src2_value), .i_src2_busy(src2_busy), .i_src2_tag(src2_tag),
    .i_fwd1_value(fwd1_value), .i_fwd1_done(fwd1_done),
    .i_fwd2_value(fwd2_value), .i_fwd2_done(fwd2_done),
    .i_rob_full(rob_full), .i_alu_rs_full(alu_rs_full), .i_mul_rs_full(mul_rs_full),
    .o_inst_ack, .o_rob_alloc(rob_alloc), .o_rename_we(rename_we),
    .o_alu_rs_we(alu_rs_we), .o_mul_rs_we(mul_rs_we),
    .o_entry_a(entry_a), .o_entry_b(entry_b),
    .o_entry_a_rdy(entry_a_rdy), .o_entry_b_rdy(entry_b_rdy),
    .o_entry_a_tag(entry_a_tag), .o_entry_b_tag(entry_b_tag), .o_entry_op(entry_op)
  );

  rename_regfile #(.ROB_DEPTH(ROB_DEPTH)) u_regfile (
    .clk_100mhz, .sys_rst, .i_rs1(i_inst_rs1), .i_rs2(i_inst_rs2),
    .i_rename_we(rename_we), .i_rename_rd(i_inst_rd), .i_rename_tag(alloc_tag),
    .i_commit_we(o_commit_valid), .i_commit_rd(o_commit_rd),
    .i_commit_tag(commit_tag), .i_commit_value(o_commit_value),
    .o_src1_value(src1_value), .o_src1_busy(src1_busy), .o_src1_tag(src1_tag),
    .o_src2_value(src2_value), .o_src2_busy(src2_busy), .o_src2_tag(src2_tag)
  );

  reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clk_100mhz, .sys_rst, .i_alloc(rob_alloc), .i_alloc_rd(i_inst_rd),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .i_fwd1_tag(src1_tag), .i_fwd2_tag(src2_tag),
    .o_alloc_tag(alloc_tag), .o_full(rob_full),
    .o_fwd1_value(fwd1_value), .o_fwd1_done(fwd1_done),
    .o_fwd2_value(fwd2_value), .o_fwd2_done(fwd2_done),
    .o_commit_valid, .o_commit_rd, .o_commit_value, .o_commit_tag(commit_tag)
  );

  reservation_station #(.ROB_DEPTH(ROB_DEPTH), .RS_ENTRIES(RS_ENTRIES)) alu_rs (
    .clk_100mhz, .sys_rst, .i_we(alu_rs_we), .i_a(entry_a), .i_b(entry_b),
    .i_a_rdy(entry_a_rdy), .i_b_rdy(entry_b_rdy), .i_a_tag(entry_a_tag),
    .i_b_tag(entry_b_tag), .i_op(entry_op), .i_tag(alloc_tag), .i_unit_ready(alu_ready),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .o_full(alu_rs_full), .o_issue_valid(alu_issue), .o_issue_a(alu_a),
    .o_issue_b(alu_b), .o_issue_op(alu_op), .o_issue_tag(alu_in_tag)
  );

  reservation_station #(.ROB_DEPTH(ROB_DEPTH), .RS_ENTRIES(RS_ENTRIES)) mul_rs (
    .clk_100mhz, .sys_rst, .i_we(mul_rs_we), .i_a(entry_a), .i_b(entry_b),
    .i_a_rdy(entry_a_rdy), .i_b_rdy(entry_b_rdy), .i_a_tag(entry_a_tag),
    .i_b_tag(entry_b_tag), .i_op(entry_op), .i_tag(alloc_tag), .i_unit_ready(mul_ready),
    .i_cdb_valid(cdb_valid), .i_cdb_tag(cdb_tag), .i_cdb_value(cdb_value),
    .o_full(mul_rs_full), .o_issue_valid(mul_issue), .o_issue_a(mul_a),
    .o_issue_b(mul_b), .o_issue_op(), .o_issue_tag(mul_in_tag)  // op is always mul
  );

  alu_unit #(.ROB_DEPTH(ROB_DEPTH)) u_alu (
    .clk_100mhz, .sys_rst, .i_valid(alu_issue), .i_a(alu_a), .i_b(alu_b),
    .i_op(alu_op), .i_tag(alu_in_tag), .i_grant(alu_grant),
    .o_ready(alu_ready), .o_result_valid(alu_res_valid),
    .o_result(alu_result), .o_result_tag(alu_res_tag)
  );

  shift_add_multiplier #(.ROB_DEPTH(ROB_DEPTH)) u_mul (
    .clk_100mhz, .sys_rst, .i_valid(mul_issue), .i_a(mul_a), .i_b(mul_b),
    .i_tag(mul_in_tag), .i_grant(mul_grant),
    .o_ready(mul_ready), .o_result_valid(mul_res_valid),
    .o_result(mul_result), .o_result_tag(mul_res_tag)
  );

  cdb_arbiter #(.ROB_DEPTH(ROB_DEPTH)) u_cdb (
    .clk_100mhz, .sys_rst,
    .i_alu_valid(alu_res_valid), .i_alu_value(alu_result), .i_alu_tag(alu_res_tag),
    .i_mul_valid(mul_res_valid), .i_mul_value(mul_result), .i_mul_tag(mul_res_tag),
    .o_alu_grant(alu_grant), .o_mul_grant(mul_grant),
    .o_cdb_valid(cdb_valid), .o_cdb_tag(cdb_tag), .o_cdb_value(cdb_value)
  );

endmodule

`default_nettype wire

//--- sim/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();
  localparam int ROB_DEPTH      = 8;
  localparam int RS_ENTRIES     = 2;
  localparam int BURST_LEN      = RS_ENTRIES + ROB_DEPTH + 2;
  localparam int RAND_LEN       = 300;
  localparam int NUM_INSTS      = 9 + 6 + 6 + 3 + BURST_LEN + RAND_LEN;
  localparam int TIMEOUT_CYCLES = NUM_INSTS * (MUL_CYCLES + 20);
  localparam int DRAIN_CYCLES   = ROB_DEPTH * (MUL_CYCLES + 20);
  localparam int FIFO_DEPTH     = 1024;

  logic     clk_100mhz;
  logic     sys_rst;
  logic     i_inst_req;
  alu_op_t  i_inst_op;
  reg_idx_t i_inst_rd;
  reg_idx_t i_inst_rs1;
  reg_idx_t i_inst_rs2;
  word_t    i_inst_imm;
  logic     o_inst_ack;
  logic     o_commit_valid;
  reg_idx_t o_commit_rd;
  word_t    o_commit_value;

  // architectural state of the model and the expected commit stream
  word_t       ref_regs     [NUM_REGS];
  reg_idx_t    exp_rd_fifo  [FIFO_DEPTH];
  word_t       exp_val_fifo [FIFO_DEPTH];
  int          wr_ptr = 0;
  int          rd_ptr = 0;
  int          ack_count = 0;
  int          commit_count = 0;
  int          max_ack_wait = 0;
  int          commit_errors = 0;
  int          handshake_errors = 0;
  int          other_errors = 0;

  ooo_core_top #(.ROB_DEPTH(ROB_DEPTH), .RS_ENTRIES(RS_ENTRIES)) i_ooo_core_top (
    .clk_100mhz, .sys_rst, .i_inst_req, .i_inst_op, .i_inst_rd, .i_inst_rs1,
    .i_inst_rs2, .i_inst_imm, .o_inst_ack, .o_commit_valid, .o_commit_rd, .o_commit_value
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  // in-order semantics of each operation
  function automatic word_t model_result(alu_op_t op, word_t a, word_t b, word_t imm);
    logic [2*XLEN-1:0] prod;
    prod = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_LI:   return imm;
      OP_MUL:  return prod[XLEN-1:0];  // low half only
      default: return '0;
    endcase
  endfunction

  task automatic model_push(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                            input reg_idx_t rs2, input word_t imm);
    word_t result;
    result = model_result(op, ref_regs[rs1], ref_regs[rs2], imm);
    if (rd != '0) ref_regs[rd] = result;  // r0 stays zero
    exp_rd_fifo[wr_ptr]  <= rd;
    exp_val_fifo[wr_ptr] <= result;
    wr_ptr <= wr_ptr + 1;
  endtask

  // four-phase req/ack for one instruction
  task automatic send_inst(input alu_op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                           input reg_idx_t rs2, input word_t imm);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge clk_100mhz);
    i_inst_req <= 1'b1;
    i_inst_op  <= op;
    i_inst_rd  <= rd;
    i_inst_rs1 <= rs1;
    i_inst_rs2 <= rs2;
    i_inst_imm <= imm;
    model_push(op, rd, rs1, rs2, imm);
    do begin
      @(posedge clk_100mhz);
      wait_cycles++;
    end while (!o_inst_ack);
    i_inst_req <= 1'b0;
    ack_count++;
    if (wait_cycles > max_ack_wait) max_ack_wait = wait_cycles;
    do @(posedge clk_100mhz); while (o_inst_ack);  // ack must fall before next req
  endtask

  task automatic send_random();
    alu_op_t  op;
    reg_idx_t rd, rs1, rs2;
    op  = alu_op_t'($urandom_range(6, 0));
    rd  = reg_idx_t'($urandom_range(NUM_REGS - 1, 0));
    rs1 = reg_idx_t'($urandom_range(NUM_REGS - 1, 0));
    rs2 = reg_idx_t'($urandom_range(NUM_REGS - 1, 0));
    send_inst(op, rd, rs1, rs2, $urandom);
  endtask

  // bounded, so missing commits show up in the final count check
  task automatic wait_drain();
    int drain_wait;
    drain_wait = 0;
    while (rd_ptr != wr_ptr && drain_wait < DRAIN_CYCLES) begin
      @(posedge clk_100mhz);
      drain_wait++;
    end
  endtask

  task automatic print_counts();
    $display("errors: commit %0d, handshake %0d, other %0d",
             commit_errors, handshake_errors, other_errors);
  endtask

  always @(posedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      rd_ptr       <= rd_ptr + 1;
      commit_count <= commit_count + 1;
    end
  end

  // commits against the oldest outstanding model result
  a_commit_rd: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> o_commit_rd == exp_rd_fifo[rd_ptr])
    else begin
      commit_errors++;
      $display("FAILED o_commit_rd: expected %h, got %h",
               $sampled(exp_rd_fifo[rd_ptr]), $sampled(o_commit_rd));
    end

  a_commit_value: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> o_commit_value == exp_val_fifo[rd_ptr])
    else begin
      commit_errors++;
      $display("FAILED o_commit_value: expected %h, got %h",
               $sampled(exp_val_fifo[rd_ptr]), $sampled(o_commit_value));
    end

  a_commit_expected: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_commit_valid |-> rd_ptr != wr_ptr)
    else begin
      commit_errors++;
      $display("commit seen with no instruction outstanding");
    end

  // req held for at least two cycles before ack
  a_ack_latency: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    $rose(o_inst_ack) |-> i_inst_req && $past(i_inst_req) && $past(i_inst_req, 2))
    else begin
      handshake_errors++;
      $display("ack rose without req held for two cycles");
    end

  a_ack_hold: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_inst_ack && i_inst_req |=> o_inst_ack)
    else begin
      handshake_errors++;
      $display("ack dropped while req was still high");
    end

  a_ack_drop: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    o_inst_ack && !i_inst_req |=> !o_inst_ack)
    else begin
      handshake_errors++;
      $display("ack stayed high after req fell");
    end

  a_ack_idle: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
    !o_inst_ack && !i_inst_req |=> !o_inst_ack)
    else begin
      handshake_errors++;
      $display("ack rose with no request pending");
    end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_100mhz);
    $display("timeout after %0d cycles, core stopped making progress", TIMEOUT_CYCLES);
    print_counts();
    $display("Test failures found");
    $finish;
  end

  initial begin
    void'($urandom(35390));
    sys_rst    = 1'b1;
    i_inst_req = 1'b0;
    i_inst_op  = OP_ADD;
    i_inst_rd  = '0;
    i_inst_rs1 = '0;
    i_inst_rs2 = '0;
    i_inst_imm = '0;
    for (int r = 0; r < NUM_REGS; r++) ref_regs[r] = '0;
    repeat (2) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
    repeat (5) @(posedge clk_100mhz);  // idle, nothing should move

    // load-immediate, then reads of r0
    for (int r = 1; r <= 6; r++) send_inst(OP_LI, reg_idx_t'(r), '0, '0, $urandom);
    send_inst(OP_LI, 4'd0, '0, '0, 32'hdead_beef);
    send_inst(OP_ADD, 4'd7, 4'd0, 4'd1, '0);
    send_inst(OP_OR, 4'd8, 4'd0, 4'd0, '0);

    // dependent alu chain
    send_inst(OP_ADD, 4'd2, 4'd1, 4'd1, '0);
    send_inst(OP_SUB, 4'd3, 4'd2, 4'd1, '0);
    send_inst(OP_XOR, 4'd4, 4'd3, 4'd2, '0);
    send_inst(OP_AND, 4'd5, 4'd4, 4'd3, '0);
    send_inst(OP_OR, 4'd6, 4'd5, 4'd2, '0);
    send_inst(OP_ADD, 4'd2, 4'd6, 4'd2, '0);

    // slow multiply ahead of quick alu ops
    send_inst(OP_LI, 4'd1, '0, '0, 32'hffff_fff3);
    send_inst(OP_LI, 4'd2, '0, '0, 32'h1234_5679);
    send_inst(OP_MUL, 4'd9, 4'd1, 4'd2, '0);
    send_inst(OP_ADD, 4'd10, 4'd3, 4'd4, '0);
    send_inst(OP_XOR, 4'd11, 4'd5, 4'd6, '0);
    send_inst(OP_SUB, 4'd12, 4'd9, 4'd10, '0);

    // multiply burst past station and rob capacity
    send_inst(OP_LI, 4'd13, '0, '0, 32'd3);
    send_inst(OP_LI, 4'd14, '0, '0, 32'd5);
    send_inst(OP_LI, 4'd15, '0, '0, 32'd7);
    max_ack_wait = 0;
    for (int i = 0; i < BURST_LEN; i++) begin
      send_inst(OP_MUL, reg_idx_t'(13 + i % 3), reg_idx_t'(1 + i % 2),
                reg_idx_t'(13 + (i + 1) % 3), '0);
    end
    assert (max_ack_wait > 3) else begin
      other_errors++;
      $display("multiply burst never held off the ack");
    end

    for (int i = 0; i < RAND_LEN; i++) send_random();
    wait_drain();
    repeat (5) @(posedge clk_100mhz);
    assert (commit_count == ack_count) else begin
      other_errors++;
      $display("FAILED commit_count: expected %h, got %h", ack_count, commit_count);
    end

    print_counts();
    if (commit_errors + handshake_errors + other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/ooo_pkg.sv
design/rename_regfile.sv
design/reorder_buffer.sv
design/reservation_station.sv
design/alu_unit.sv
design/shift_add_multiplier.sv
design/cdb_arbiter.sv
design/dispatch_ctrl.sv
design/ooo_core_top.sv
sim/tb_ooo_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the out-of-order core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_ooo_core -f vlog.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_ooo_core >> sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "simulation PASS" \
  || { echo "simulation FAIL, see sim.log"; exit 1; }
